// ==== verilog/ntm_arith_pkg.sv ====
package ntm_arith_pkg;

  //////////////////////////////////////////////////
  // Modular arithmetic constants
  //////////////////////////////////////////////////

  // Residue and bus word width
  localparam int DATA_SIZE = 32;

  // Adder operation select
  localparam logic OP_ADD = 1'b0;
  localparam logic OP_SUB = 1'b1;

endpackage

// ==== verilog/ntm_matrix_pkg.sv ====
package ntm_matrix_pkg;

  //////////////////////////////////////////////////
  // Matrix geometry
  //////////////////////////////////////////////////

  // Largest supported order
  localparam int MAX_ORDER = 4;
  // Row or column index width
  localparam int INDEX_SIZE = 2;
  // Store depth, MAX_ORDER squared
  localparam int ELEMENTS = 16;

  //////////////////////////////////////////////////
  // Bus register map
  //////////////////////////////////////////////////

  // Word address width
  localparam int ADDR_SIZE = 5;

  localparam logic [3:0] REG_CTRL   = 4'd0;
  localparam logic [3:0] REG_MODULO = 4'd1;
  localparam logic [3:0] REG_ORDER  = 4'd2;
  localparam logic [3:0] REG_STATUS = 4'd3;
  localparam logic [3:0] REG_RESULT = 4'd4;

  // Register view, region bit low
  typedef struct packed {
    logic       region;
    logic [3:0] index;
  } wb_reg_addr_t;

  // Element view, region bit high
  typedef struct packed {
    logic                  region;
    logic [INDEX_SIZE-1:0] row;
    logic [INDEX_SIZE-1:0] col;
  } wb_elem_addr_t;

  // Same address word seen both ways
  typedef union packed {
    wb_reg_addr_t  regs;
    wb_elem_addr_t elem;
  } wb_addr_t;

endpackage

// ==== verilog/ntm_scalar_adder.sv ====
`timescale 1ns/1ps

module ntm_scalar_adder (
  input  logic                                CLK,
  input  logic                                RST,
  input  logic                                START,
  input  logic                                OPERATION,
  input  logic [ntm_arith_pkg::DATA_SIZE-1:0] MODULO_IN,
  input  logic [ntm_arith_pkg::DATA_SIZE-1:0] DATA_A_IN,
  input  logic [ntm_arith_pkg::DATA_SIZE-1:0] DATA_B_IN,
  output logic                                READY,
  output logic [ntm_arith_pkg::DATA_SIZE-1:0] DATA_OUT
);

  // Extra top bit keeps carry or borrow
  logic [ntm_arith_pkg::DATA_SIZE:0]   raw;
  logic [ntm_arith_pkg::DATA_SIZE:0]   fixed;
  logic [ntm_arith_pkg::DATA_SIZE-1:0] result;

  always_comb begin
    if (OPERATION == ntm_arith_pkg::OP_SUB) begin
      raw   = {1'b0, DATA_A_IN} - {1'b0, DATA_B_IN};
      fixed = raw + {1'b0, MODULO_IN};
      // Borrow out, wrap back up by the modulus
      result = raw[ntm_arith_pkg::DATA_SIZE] ? fixed[ntm_arith_pkg::DATA_SIZE-1:0] :
                                               raw[ntm_arith_pkg::DATA_SIZE-1:0];
    end else begin
      raw   = {1'b0, DATA_A_IN} + {1'b0, DATA_B_IN};
      fixed = raw - {1'b0, MODULO_IN};
      // Sum below 2m, one correction is enough
      result = (raw >= {1'b0, MODULO_IN}) ? fixed[ntm_arith_pkg::DATA_SIZE-1:0] :
                                             raw[ntm_arith_pkg::DATA_SIZE-1:0];
    end
  end

  // Single cycle handshake
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY <= 1'b0;
    end else begin
      READY <= START;
    end
  end

  always_ff @(posedge CLK) begin
    if (START) begin
      DATA_OUT <= result;
    end
  end

endmodule

// ==== verilog/ntm_scalar_multiplier.sv ====
`timescale 1ns/1ps

module ntm_scalar_multiplier (
  input  logic                                CLK,
  input  logic                                RST,
  input  logic                                START,
  input  logic [ntm_arith_pkg::DATA_SIZE-1:0] MODULO_IN,
  input  logic [ntm_arith_pkg::DATA_SIZE-1:0] DATA_A_IN,
  input  logic [ntm_arith_pkg::DATA_SIZE-1:0] DATA_B_IN,
  output logic                                READY,
  output logic [ntm_arith_pkg::DATA_SIZE-1:0] DATA_OUT
);

  logic                                       busy;
  logic [$clog2(ntm_arith_pkg::DATA_SIZE):0]  steps;
  logic [ntm_arith_pkg::DATA_SIZE-1:0]        acc;
  logic [ntm_arith_pkg::DATA_SIZE-1:0]        b_shift;
  // Two guard bits, 2*acc + A stays below 3m
  logic [ntm_arith_pkg::DATA_SIZE+1:0]        t_add;
  logic [ntm_arith_pkg::DATA_SIZE+1:0]        t_red1;
  logic [ntm_arith_pkg::DATA_SIZE+1:0]        t_red2;
  logic [ntm_arith_pkg::DATA_SIZE+1:0]        m_ext;

  //////////////////////////////////////////////////
  // One interleaved step, MSB of B first
  //////////////////////////////////////////////////

  always_comb begin
    m_ext  = {2'b00, MODULO_IN};
    t_add  = {1'b0, acc, 1'b0};
    if (b_shift[ntm_arith_pkg::DATA_SIZE-1]) begin
      t_add = t_add + {2'b00, DATA_A_IN};
    end
    t_red1 = (t_add >= m_ext) ? t_add - m_ext : t_add;
    t_red2 = (t_red1 >= m_ext) ? t_red1 - m_ext : t_red1;
  end

  // Step counter and handshake
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      steps <= '0;
      READY <= 1'b0;
    end else begin
      READY <= 1'b0;
      if (START) begin
        busy  <= 1'b1;
        steps <= ($clog2(ntm_arith_pkg::DATA_SIZE)+1)'(ntm_arith_pkg::DATA_SIZE);
      end else if (busy) begin
        if (steps == '0) begin
          busy  <= 1'b0;
          READY <= 1'b1;
        end else begin
          steps <= steps - 1'b1;
        end
      end
    end
  end

  // Partial result and operand shifter
  always_ff @(posedge CLK) begin
    if (START) begin
      acc     <= '0;
      b_shift <= DATA_B_IN;
    end else if (busy && steps != '0) begin
      acc     <= t_red2[ntm_arith_pkg::DATA_SIZE-1:0];
      b_shift <= b_shift << 1;
    end
    if (busy && steps == '0) begin
      DATA_OUT <= acc;
    end
  end

endmodule

// ==== verilog/ntm_matrix_determinant.sv ====
`timescale 1ns/1ps

module ntm_matrix_determinant (
  input  logic                                CLK,
  input  logic                                RST,
  input  logic                                START,
  input  logic                                DATA_IN_I_ENABLE,
  input  logic                                DATA_IN_J_ENABLE,
  input  logic [ntm_arith_pkg::DATA_SIZE-1:0] MODULO_IN,
  input  logic [ntm_arith_pkg::DATA_SIZE-1:0] SIZE_IN,
  input  logic [ntm_arith_pkg::DATA_SIZE-1:0] DATA_IN,
  output logic                                READY,
  output logic                                DATA_OUT_I_ENABLE,
  output logic                                DATA_OUT_J_ENABLE,
  output logic [ntm_arith_pkg::DATA_SIZE-1:0] DATA_OUT
);

  // FSM encoding
  localparam logic [2:0] STARTER_STATE    = 3'd0;
  localparam logic [2:0] LOADER_STATE     = 3'd1;
  localparam logic [2:0] MULTIPLIER_STATE = 3'd2;
  localparam logic [2:0] ADDER_STATE      = 3'd3;
  localparam logic [2:0] PERMUTER_STATE   = 3'd4;
  localparam logic [2:0] ENDER_STATE      = 3'd5;

  logic [2:0]                              state;
  logic [ntm_matrix_pkg::INDEX_SIZE:0]     order;
  logic [ntm_matrix_pkg::INDEX_SIZE-1:0]   last;
  logic [ntm_matrix_pkg::INDEX_SIZE-1:0]   row;
  logic [ntm_matrix_pkg::INDEX_SIZE-1:0]   col;
  logic [ntm_matrix_pkg::INDEX_SIZE-1:0]   load_col;
  logic                                    load_fire;
  logic [ntm_arith_pkg::DATA_SIZE-1:0]     matrix [ntm_matrix_pkg::ELEMENTS];
  logic [ntm_arith_pkg::DATA_SIZE-1:0]     element;

  // Heap's algorithm state
  logic [ntm_matrix_pkg::INDEX_SIZE-1:0]   perm   [ntm_matrix_pkg::MAX_ORDER];
  logic [ntm_matrix_pkg::INDEX_SIZE-1:0]   heap_c [ntm_matrix_pkg::MAX_ORDER];
  logic [ntm_matrix_pkg::INDEX_SIZE:0]     heap_i;
  logic [ntm_matrix_pkg::INDEX_SIZE-1:0]   swap_a;
  logic [ntm_matrix_pkg::INDEX_SIZE-1:0]   swap_b;
  logic                                    parity;

  logic                                    pending;
  logic [ntm_arith_pkg::DATA_SIZE-1:0]     product;
  logic [ntm_arith_pkg::DATA_SIZE-1:0]     acc;

  // Arithmetic handshakes
  logic                                    start_mul;
  logic                                    ready_mul;
  logic [ntm_arith_pkg::DATA_SIZE-1:0]     mul_out;
  logic                                    start_add;
  logic                                    ready_add;
  logic                                    add_op;
  logic [ntm_arith_pkg::DATA_SIZE-1:0]     add_out;

  //////////////////////////////////////////////////
  // Stream side
  //////////////////////////////////////////////////

  // Order 4 wraps to index 3 on purpose
  assign order = SIZE_IN[ntm_matrix_pkg::INDEX_SIZE:0];
  assign last  = order[ntm_matrix_pkg::INDEX_SIZE-1:0] - 1'b1;

  assign DATA_OUT_J_ENABLE = (state == LOADER_STATE);
  assign DATA_OUT_I_ENABLE = (state == LOADER_STATE) && (col == '0);
  // Row marker from the sender realigns the column
  assign load_col  = DATA_IN_I_ENABLE ? '0 : col;
  assign load_fire = DATA_OUT_J_ENABLE && DATA_IN_J_ENABLE;

  always_ff @(posedge CLK) begin
    if (load_fire) begin
      matrix[{row, load_col}] <= DATA_IN;
    end
  end

  // Factor a(row, perm(row))
  assign element = matrix[{row, perm[row]}];

  // Even i swaps with 0, odd i with c[i]
  assign swap_b = heap_i[ntm_matrix_pkg::INDEX_SIZE-1:0];
  assign swap_a = heap_i[0] ? heap_c[swap_b] : '0;
  assign add_op = parity ? ntm_arith_pkg::OP_SUB : ntm_arith_pkg::OP_ADD;

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= STARTER_STATE;
      READY     <= 1'b0;
      DATA_OUT  <= '0;
      start_mul <= 1'b0;
      start_add <= 1'b0;
      pending   <= 1'b0;
      row       <= '0;
      col       <= '0;
      heap_i    <= '0;
      parity    <= 1'b0;
      product   <= '0;
      acc       <= '0;
      for (int k = 0; k < ntm_matrix_pkg::MAX_ORDER; k++) begin
        perm[k]   <= '0;
        heap_c[k] <= '0;
      end
    end else begin
      READY     <= 1'b0;
      start_mul <= 1'b0;
      start_add <= 1'b0;
      case (state)
        STARTER_STATE: begin
          if (START) begin
            row   <= '0;
            col   <= '0;
            state <= LOADER_STATE;
          end
        end
        LOADER_STATE: begin
          if (load_fire) begin
            if (load_col == last) begin
              col <= '0;
              if (row == last) begin
                // Matrix complete, identity permutation first
                row     <= '0;
                acc     <= '0;
                product <= ntm_arith_pkg::DATA_SIZE'(1);
                parity  <= 1'b0;
                heap_i  <= (ntm_matrix_pkg::INDEX_SIZE+1)'(1);
                for (int k = 0; k < ntm_matrix_pkg::MAX_ORDER; k++) begin
                  perm[k]   <= ntm_matrix_pkg::INDEX_SIZE'(k);
                  heap_c[k] <= '0;
                end
                state <= MULTIPLIER_STATE;
              end else begin
                row <= row + 1'b1;
              end
            end else begin
              col <= load_col + 1'b1;
            end
          end
        end
        MULTIPLIER_STATE: begin
          if (!pending) begin
            start_mul <= 1'b1;
            pending   <= 1'b1;
          end else if (ready_mul) begin
            pending <= 1'b0;
            product <= mul_out;
            if (row == last) begin
              row   <= '0;
              state <= ADDER_STATE;
            end else begin
              row <= row + 1'b1;
            end
          end
        end
        ADDER_STATE: begin
          // Signed accumulate by permutation parity
          if (!pending) begin
            start_add <= 1'b1;
            pending   <= 1'b1;
          end else if (ready_add) begin
            pending <= 1'b0;
            acc     <= add_out;
            product <= ntm_arith_pkg::DATA_SIZE'(1);
            state   <= PERMUTER_STATE;
          end
        end
        PERMUTER_STATE: begin
          if (heap_i >= order) begin
            // Every permutation visited
            state <= ENDER_STATE;
          end else if ({1'b0, heap_c[swap_b]} < heap_i) begin
            perm[swap_a]   <= perm[swap_b];
            perm[swap_b]   <= perm[swap_a];
            heap_c[swap_b] <= heap_c[swap_b] + 1'b1;
            parity         <= ~parity;
            heap_i         <= (ntm_matrix_pkg::INDEX_SIZE+1)'(1);
            state          <= MULTIPLIER_STATE;
          end else begin
            heap_c[swap_b] <= '0;
            heap_i         <= heap_i + 1'b1;
          end
        end
        ENDER_STATE: begin
          READY    <= 1'b1;
          DATA_OUT <= acc;
          state    <= STARTER_STATE;
        end
        default: begin
          state <= STARTER_STATE;
        end
      endcase
    end
  end

  // Shared product unit
  ntm_scalar_multiplier ntm_scalar_multiplier_i (
    .CLK       (CLK),
    .RST       (RST),
    .START     (start_mul),
    .MODULO_IN (MODULO_IN),
    .DATA_A_IN (product),
    .DATA_B_IN (element),
    .READY     (ready_mul),
    .DATA_OUT  (mul_out)
  );

  // Accumulator update
  ntm_scalar_adder ntm_scalar_adder_i (
    .CLK       (CLK),
    .RST       (RST),
    .START     (start_add),
    .OPERATION (add_op),
    .MODULO_IN (MODULO_IN),
    .DATA_A_IN (acc),
    .DATA_B_IN (product),
    .READY     (ready_add),
    .DATA_OUT  (add_out)
  );

endmodule

// ==== verilog/ntm_determinant_wb_slave.sv ====
`timescale 1ns/1ps

module ntm_determinant_wb_slave (
  input  logic                                 CLK,
  input  logic                                 RST,
  input  logic                                 WB_CYC,
  input  logic                                 WB_STB,
  input  logic                                 WB_WE,
  input  logic [ntm_matrix_pkg::ADDR_SIZE-1:0] WB_ADR,
  input  logic [ntm_arith_pkg::DATA_SIZE-1:0]  WB_DAT_I,
  output logic [ntm_arith_pkg::DATA_SIZE-1:0]  WB_DAT_O,
  output logic                                 WB_ACK,
  output logic                                 START,
  output logic                                 DATA_IN_I_ENABLE,
  output logic                                 DATA_IN_J_ENABLE,
  output logic [ntm_arith_pkg::DATA_SIZE-1:0]  MODULO_IN,
  output logic [ntm_arith_pkg::DATA_SIZE-1:0]  SIZE_IN,
  output logic [ntm_arith_pkg::DATA_SIZE-1:0]  DATA_IN,
  input  logic                                 READY,
  input  logic                                 DATA_OUT_I_ENABLE,
  input  logic                                 DATA_OUT_J_ENABLE,
  input  logic [ntm_arith_pkg::DATA_SIZE-1:0]  DATA_OUT
);

  ntm_matrix_pkg::wb_addr_t                 adr;
  logic [ntm_arith_pkg::DATA_SIZE-1:0]      store [ntm_matrix_pkg::ELEMENTS];
  logic [ntm_arith_pkg::DATA_SIZE-1:0]      modulo_r;
  logic [ntm_arith_pkg::DATA_SIZE-1:0]      result_r;
  logic [ntm_arith_pkg::DATA_SIZE-1:0]      rd_data;
  logic [ntm_matrix_pkg::INDEX_SIZE:0]      order_r;
  logic [ntm_matrix_pkg::INDEX_SIZE-1:0]    last;
  logic [ntm_matrix_pkg::INDEX_SIZE-1:0]    s_row;
  logic [ntm_matrix_pkg::INDEX_SIZE-1:0]    s_col;
  logic [ntm_matrix_pkg::INDEX_SIZE-1:0]    cur_col;
  logic                                     busy;
  logic                                     done;
  logic                                     streaming;
  logic                                     access;
  logic                                     advance;

  //////////////////////////////////////////////////
  // Bus decode
  //////////////////////////////////////////////////

  assign adr = WB_ADR;
  // New access only while ACK is low
  assign access = WB_CYC && WB_STB && !WB_ACK;

  always_comb begin
    rd_data = '0;
    if (adr.elem.region) begin
      rd_data = store[{adr.elem.row, adr.elem.col}];
    end else begin
      case (adr.regs.index)
        ntm_matrix_pkg::REG_MODULO: rd_data = modulo_r;
        ntm_matrix_pkg::REG_ORDER:  rd_data = SIZE_IN;
        ntm_matrix_pkg::REG_STATUS: rd_data = {{(ntm_arith_pkg::DATA_SIZE-2){1'b0}}, done, busy};
        ntm_matrix_pkg::REG_RESULT: rd_data = result_r;
        default:                    rd_data = '0;
      endcase
    end
  end

  // Element store, out-of-order cells kept as written
  always_ff @(posedge CLK) begin
    if (access && WB_WE && adr.elem.region) begin
      store[{adr.elem.row, adr.elem.col}] <= WB_DAT_I;
    end
  end

  //////////////////////////////////////////////////
  // Element stream
  //////////////////////////////////////////////////

  assign MODULO_IN = modulo_r;
  assign SIZE_IN   = {{(ntm_arith_pkg::DATA_SIZE-ntm_matrix_pkg::INDEX_SIZE-1){1'b0}}, order_r};
  assign last      = order_r[ntm_matrix_pkg::INDEX_SIZE-1:0] - 1'b1;

  // Receiver waiting on a row start means column 0
  assign cur_col          = DATA_OUT_I_ENABLE ? '0 : s_col;
  assign DATA_IN          = store[{s_row, cur_col}];
  assign DATA_IN_J_ENABLE = streaming;
  assign DATA_IN_I_ENABLE = streaming && (cur_col == '0);
  // Element and enables hold until accepted
  assign advance          = streaming && DATA_OUT_J_ENABLE;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      WB_ACK    <= 1'b0;
      WB_DAT_O  <= '0;
      START     <= 1'b0;
      modulo_r  <= '0;
      order_r   <= '0;
      result_r  <= '0;
      busy      <= 1'b0;
      done      <= 1'b0;
      streaming <= 1'b0;
      s_row     <= '0;
      s_col     <= '0;
    end else begin
      WB_ACK <= access;
      START  <= 1'b0;
      if (access && !WB_WE) begin
        WB_DAT_O <= rd_data;
      end
      // Register writes, operands frozen while busy
      if (access && WB_WE && !adr.regs.region && !busy) begin
        case (adr.regs.index)
          ntm_matrix_pkg::REG_CTRL: begin
            if (WB_DAT_I[0]) begin
              START     <= 1'b1;
              busy      <= 1'b1;
              done      <= 1'b0;
              streaming <= 1'b1;
              s_row     <= '0;
              s_col     <= '0;
            end
          end
          ntm_matrix_pkg::REG_MODULO: modulo_r <= WB_DAT_I;
          ntm_matrix_pkg::REG_ORDER:  order_r  <= WB_DAT_I[ntm_matrix_pkg::INDEX_SIZE:0];
          default: ;
        endcase
      end
      // Row-major walk over the active square
      if (advance) begin
        if (cur_col == last) begin
          s_col <= '0;
          if (s_row == last) begin
            streaming <= 1'b0;
          end else begin
            s_row <= s_row + 1'b1;
          end
        end else begin
          s_col <= cur_col + 1'b1;
        end
      end
      if (READY) begin
        result_r <= DATA_OUT;
        busy     <= 1'b0;
        done     <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/ntm_determinant_top.sv ====
`timescale 1ns/1ps

module ntm_determinant_top (
  input  logic                                 CLK,
  input  logic                                 RST,
  input  logic                                 WB_CYC,
  input  logic                                 WB_STB,
  input  logic                                 WB_WE,
  input  logic [ntm_matrix_pkg::ADDR_SIZE-1:0] WB_ADR,
  input  logic [ntm_arith_pkg::DATA_SIZE-1:0]  WB_DAT_I,
  output logic [ntm_arith_pkg::DATA_SIZE-1:0]  WB_DAT_O,
  output logic                                 WB_ACK
);

  // Slave to determinant handshake
  logic                                start;
  logic                                ready;
  logic                                in_i_enable;
  logic                                in_j_enable;
  logic                                out_i_enable;
  logic                                out_j_enable;
  logic [ntm_arith_pkg::DATA_SIZE-1:0] modulo;
  logic [ntm_arith_pkg::DATA_SIZE-1:0] size;
  logic [ntm_arith_pkg::DATA_SIZE-1:0] data_in;
  logic [ntm_arith_pkg::DATA_SIZE-1:0] data_out;

  ntm_determinant_wb_slave ntm_determinant_wb_slave_i (
    .CLK               (CLK),
    .RST               (RST),
    .WB_CYC            (WB_CYC),
    .WB_STB            (WB_STB),
    .WB_WE             (WB_WE),
    .WB_ADR            (WB_ADR),
    .WB_DAT_I          (WB_DAT_I),
    .WB_DAT_O          (WB_DAT_O),
    .WB_ACK            (WB_ACK),
    .START             (start),
    .DATA_IN_I_ENABLE  (in_i_enable),
    .DATA_IN_J_ENABLE  (in_j_enable),
    .MODULO_IN         (modulo),
    .SIZE_IN           (size),
    .DATA_IN           (data_in),
    .READY             (ready),
    .DATA_OUT_I_ENABLE (out_i_enable),
    .DATA_OUT_J_ENABLE (out_j_enable),
    .DATA_OUT          (data_out)
  );

  ntm_matrix_determinant ntm_matrix_determinant_i (
    .CLK               (CLK),
    .RST               (RST),
    .START             (start),
    .DATA_IN_I_ENABLE  (in_i_enable),
    .DATA_IN_J_ENABLE  (in_j_enable),
    .MODULO_IN         (modulo),
    .SIZE_IN           (size),
    .DATA_IN           (data_in),
    .READY             (ready),
    .DATA_OUT_I_ENABLE (out_i_enable),
    .DATA_OUT_J_ENABLE (out_j_enable),
    .DATA_OUT          (data_out)
  );

endmodule

// ==== test/ntm_determinant_tb_ref.svh ====
`ifndef NTM_DETERMINANT_TB_REF_SVH
`define NTM_DETERMINANT_TB_REF_SVH

// Laplace expansion along the top free row
// used marks columns already taken by the rows above
function automatic logic [63:0] ref_minor(input int row, input logic [3:0] used,
                                          input int order, input logic [63:0] p);
  logic [63:0] sum;
  logic [63:0] term;
  int          pos;
  // Empty minor
  if (row == order) begin
    return 64'd1;
  end
  sum = 64'd0;
  pos = 0;
  for (int c = 0; c < order; c++) begin
    if (!used[c]) begin
      term = 64'(mat[row*ntm_matrix_pkg::MAX_ORDER+c]) % p;
      term = (term * ref_minor(row + 1, used | (4'b0001 << c), order, p)) % p;
      // Sign alternates over the free columns only
      if (pos % 2 == 0) begin
        sum = (sum + term) % p;
      end else begin
        sum = (sum + p - term) % p;
      end
      pos++;
    end
  end
  return sum;
endfunction

// Determinant of the top left order x order block, mod p
function automatic logic [31:0] ref_determinant(input int order, input logic [31:0] p);
  return 32'(ref_minor(0, 4'b0000, order, 64'(p)));
endfunction

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("error: %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
  end
endtask

`endif

// ==== test/ntm_determinant_tb.sv ====
`timescale 1ns/1ps

module ntm_determinant_tb;

  localparam int CLK_PERIOD = 4;
  // 8 diagonal, 40 random, 3 row tests, 1 busy test
  localparam int RUNS = 52;
  // Worst case 4x4 is 24 permutations of 4 products plus bus traffic
  localparam int RUN_CYCLES = 24 * ntm_matrix_pkg::MAX_ORDER *
                              (ntm_arith_pkg::DATA_SIZE + 8) + 200;
  localparam int TIMEOUT_CYCLES = RUNS * RUN_CYCLES + 2000;

  logic        CLK;
  logic        RST;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [4:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  // Row-major host copy of the matrix
  logic [31:0] mat [ntm_matrix_pkg::ELEMENTS];
  int          check_count;
  int          error_count;
  int          done_rises = 0;
  logic        done_seen = 1'b0;
  logic [31:0] got_q [$];
  logic [31:0] exp_q [$];

  `include "ntm_determinant_tb_ref.svh"

  ntm_determinant_top ntm_determinant_top_i (
    .CLK      (CLK),
    .RST      (RST),
    .WB_CYC   (wb_cyc),
    .WB_STB   (wb_stb),
    .WB_WE    (wb_we),
    .WB_ADR   (wb_adr),
    .WB_DAT_I (wb_dat_w),
    .WB_DAT_O (wb_dat_r),
    .WB_ACK   (wb_ack)
  );

  always #(CLK_PERIOD/2) CLK = ~CLK;

  //////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////

  // Drains the results queued by the sequence
  always @(posedge CLK) begin : compare_results
    logic [31:0] got;
    logic [31:0] exp;
    while (got_q.size() > 0) begin
      got = got_q.pop_front();
      exp = exp_q.pop_front();
      check_value("RESULT", got, exp);
    end
  end

  // Rising edges of the done flag
  always @(negedge CLK) begin
    done_seen <= ntm_determinant_top_i.ntm_determinant_wb_slave_i.done;
    if (ntm_determinant_top_i.ntm_determinant_wb_slave_i.done && !done_seen) begin
      done_rises <= done_rises + 1;
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge CLK);
    $display("watchdog expired after %0d cycles, the DUT seems to hang", TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // Address and bus helpers
  //////////////////////////////////////////////////

  function automatic logic [4:0] reg_addr(input logic [3:0] index);
    ntm_matrix_pkg::wb_addr_t a;
    a.regs.region = 1'b0;
    a.regs.index  = index;
    return a;
  endfunction

  function automatic logic [4:0] elem_addr(input int row, input int col);
    ntm_matrix_pkg::wb_addr_t a;
    a.elem.region = 1'b1;
    a.elem.row    = ntm_matrix_pkg::INDEX_SIZE'(row);
    a.elem.col    = ntm_matrix_pkg::INDEX_SIZE'(col);
    return a;
  endfunction

  // Classic cycle held until ACK
  task automatic write_word(input logic [4:0] addr, input logic [31:0] data);
    @(negedge CLK);
    // ACK of the previous access lasts one cycle
    check_value("WB_ACK", 32'(wb_ack), 32'd0);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = addr;
    wb_dat_w = data;
    @(negedge CLK);
    while (!wb_ack) @(negedge CLK);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic read_word(input logic [4:0] addr, output logic [31:0] data);
    @(negedge CLK);
    // ACK of the previous access lasts one cycle
    check_value("WB_ACK", 32'(wb_ack), 32'd0);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = addr;
    @(negedge CLK);
    while (!wb_ack) @(negedge CLK);
    // Read data valid with ACK
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Matrix and run helpers
  //////////////////////////////////////////////////

  function automatic bit is_prime(input logic [31:0] n);
    longint d;
    if (n < 2) begin
      return 1'b0;
    end
    if (n % 2 == 0) begin
      return n == 2;
    end
    for (d = 3; d * d <= n; d += 2) begin
      if (n % d == 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Odd candidates below 2^31 until one is prime
  function automatic logic [31:0] random_prime();
    logic [31:0] cand;
    cand = ($urandom & 32'h7fff_ffff) | 32'h1;
    while (!is_prime(cand)) begin
      cand = ($urandom & 32'h7fff_ffff) | 32'h1;
    end
    return cand;
  endfunction

  // Residues inside the square and raw garbage outside
  task automatic fill_random(input int order, input logic [31:0] p);
    for (int r = 0; r < ntm_matrix_pkg::MAX_ORDER; r++) begin
      for (int c = 0; c < ntm_matrix_pkg::MAX_ORDER; c++) begin
        if (r < order && c < order) begin
          mat[r*ntm_matrix_pkg::MAX_ORDER+c] = $urandom % p;
        end else begin
          mat[r*ntm_matrix_pkg::MAX_ORDER+c] = $urandom;
        end
      end
    end
  endtask

  // Zero off-diagonal so the determinant is the diagonal product
  task automatic make_diagonal(input int order, input logic [31:0] p, input bit identity,
                               output logic [31:0] expected);
    logic [63:0] prod;
    prod = 64'd1;
    for (int r = 0; r < order; r++) begin
      for (int c = 0; c < order; c++) begin
        if (r != c) begin
          mat[r*ntm_matrix_pkg::MAX_ORDER+c] = 32'd0;
        end else if (identity) begin
          mat[r*ntm_matrix_pkg::MAX_ORDER+c] = 32'd1;
        end
      end
      prod = (prod * mat[r*ntm_matrix_pkg::MAX_ORDER+r]) % p;
    end
    expected = prod[31:0];
  endtask

  task automatic load_matrix(input int order, input logic [31:0] p);
    write_word(reg_addr(ntm_matrix_pkg::REG_MODULO), p);
    write_word(reg_addr(ntm_matrix_pkg::REG_ORDER), 32'(order));
    for (int r = 0; r < ntm_matrix_pkg::MAX_ORDER; r++) begin
      for (int c = 0; c < ntm_matrix_pkg::MAX_ORDER; c++) begin
        write_word(elem_addr(r, c), mat[r*ntm_matrix_pkg::MAX_ORDER+c]);
      end
    end
  endtask

  task automatic queue_result(input logic [31:0] expected);
    logic [31:0] value;
    read_word(reg_addr(ntm_matrix_pkg::REG_RESULT), value);
    got_q.push_back(value);
    exp_q.push_back(expected);
  endtask

  // Poll STATUS until done
  task automatic wait_done();
    logic [31:0] status;
    read_word(reg_addr(ntm_matrix_pkg::REG_STATUS), status);
    while (!status[1]) begin
      read_word(reg_addr(ntm_matrix_pkg::REG_STATUS), status);
    end
  endtask

  task automatic compute_result(input logic [31:0] expected);
    write_word(reg_addr(ntm_matrix_pkg::REG_CTRL), 32'd1);
    wait_done();
    queue_result(expected);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : main_sequence
    logic [31:0] value;
    logic [31:0] p;
    logic [31:0] expected;
    logic [31:0] tmp;
    int          order;
    int          rises;
    CLK         = 1'b0;
    RST         = 1'b1;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    check_count = 0;
    error_count = 0;
    void'($urandom(32'h3b2e));
    repeat (8) @(negedge CLK);
    RST = 1'b0;

    // Reset values
    read_word(reg_addr(ntm_matrix_pkg::REG_STATUS), value);
    check_value("STATUS", value, 32'd0);
    queue_result(32'd0);

    // Register readback
    p = $urandom;
    write_word(reg_addr(ntm_matrix_pkg::REG_MODULO), p);
    write_word(reg_addr(ntm_matrix_pkg::REG_ORDER), 32'd3);
    read_word(reg_addr(ntm_matrix_pkg::REG_MODULO), value);
    check_value("MODULO", value, p);
    read_word(reg_addr(ntm_matrix_pkg::REG_ORDER), value);
    check_value("ORDER", value, 32'd3);

    // Identity then random diagonal for every order
    for (order = 1; order <= ntm_matrix_pkg::MAX_ORDER; order++) begin
      p = random_prime();
      fill_random(order, p);
      make_diagonal(order, p, 1'b1, expected);
      load_matrix(order, p);
      compute_result(expected);
      fill_random(order, p);
      make_diagonal(order, p, 1'b0, expected);
      load_matrix(order, p);
      compute_result(expected);
    end

    // Random orders and moduli
    repeat (40) begin
      order = 1 + ($urandom % ntm_matrix_pkg::MAX_ORDER);
      p = random_prime();
      fill_random(order, p);
      load_matrix(order, p);
      compute_result(ref_determinant(order, p));
    end

    // Two equal rows
    p = random_prime();
    fill_random(4, p);
    for (int c = 0; c < 4; c++) begin
      mat[2*ntm_matrix_pkg::MAX_ORDER+c] = mat[c];
    end
    load_matrix(4, p);
    compute_result(32'd0);

    // Row swap negates the determinant
    p = random_prime();
    fill_random(4, p);
    expected = ref_determinant(4, p);
    load_matrix(4, p);
    compute_result(expected);
    for (int c = 0; c < 4; c++) begin
      tmp = mat[ntm_matrix_pkg::MAX_ORDER+c];
      mat[ntm_matrix_pkg::MAX_ORDER+c]   = mat[3*ntm_matrix_pkg::MAX_ORDER+c];
      mat[3*ntm_matrix_pkg::MAX_ORDER+c] = tmp;
    end
    load_matrix(4, p);
    compute_result((p - expected) % p);

    // Second start while busy must be dropped
    p = random_prime();
    fill_random(4, p);
    load_matrix(4, p);
    rises = done_rises;
    write_word(reg_addr(ntm_matrix_pkg::REG_CTRL), 32'd1);
    read_word(reg_addr(ntm_matrix_pkg::REG_STATUS), value);
    check_value("STATUS", value, 32'd1);
    write_word(reg_addr(ntm_matrix_pkg::REG_CTRL), 32'd1);
    read_word(reg_addr(ntm_matrix_pkg::REG_STATUS), value);
    check_value("STATUS", value, 32'd1);
    wait_done();
    queue_result(ref_determinant(4, p));
    repeat (8) begin
      read_word(reg_addr(ntm_matrix_pkg::REG_STATUS), value);
      check_value("STATUS", value, 32'd2);
    end
    check_value("done_rises", 32'(done_rises - rises), 32'd1);

    // Let the compare process catch up
    while (got_q.size() != 0) @(negedge CLK);
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+test
verilog/ntm_arith_pkg.sv
verilog/ntm_matrix_pkg.sv
verilog/ntm_scalar_adder.sv
verilog/ntm_scalar_multiplier.sv
verilog/ntm_matrix_determinant.sv
verilog/ntm_determinant_wb_slave.sv
verilog/ntm_determinant_top.sv
test/ntm_determinant_tb.sv

// ==== Bender.yml ====
package:
  name: ntm_determinant

sources:
  # Packages first, then leaf blocks up to the top level
  - files:
      - verilog/ntm_arith_pkg.sv
      - verilog/ntm_matrix_pkg.sv
      - verilog/ntm_scalar_adder.sv
      - verilog/ntm_scalar_multiplier.sv
      - verilog/ntm_matrix_determinant.sv
      - verilog/ntm_determinant_wb_slave.sv
      - verilog/ntm_determinant_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/ntm_determinant_tb.sv
